// ==== verilog/usbTxPkg.sv ====
// USB transmit link types, register map and protocol constants
`default_nettype none

package usbTxPkg;

    // Line symbols, J doubles as logic one inside the bit stream
    typedef enum logic [1:0] {
        busK   = 2'd0,
        busJ   = 2'd1,
        busSe0 = 2'd2
    } busState;

    typedef enum logic [3:0] {
        pidOut   = 4'b0001,
        pidIn    = 4'b1001,
        pidData0 = 4'b0011,
        pidAck   = 4'b0010,
        pidNak   = 4'b1010
    } pidT;

    // Packet kind as written in the control word
    typedef enum logic [2:0] {
        kindOut   = 3'd0,
        kindIn    = 3'd1,
        kindData0 = 3'd2,
        kindAck   = 3'd3,
        kindNak   = 3'd4
    } pktKindT;

    // APB register offsets
    localparam logic [7:0] CTRL_ADDR    = 8'h00;
    localparam logic [7:0] DATA_LO_ADDR = 8'h04;
    localparam logic [7:0] DATA_HI_ADDR = 8'h08;
    localparam logic [7:0] STATUS_ADDR  = 8'h0C;

    // Control word layout
    localparam int KIND_LSB = 0;
    localparam int ADDR_LSB = 3;
    localparam int ENDP_LSB = 10;
    localparam int KIND_W   = 3;

    localparam int APB_DW     = 32;
    localparam int PAYLOAD_W  = 64;
    localparam int DEV_ADDR_W = 7;
    localparam int ENDP_W     = 4;

    // CRC generators, both preset to all ones
    localparam int              CRC5_W     = 5;
    localparam logic [4:0]      CRC5_POLY  = 5'h05;
    localparam int              CRC16_W    = 16;
    localparam logic [15:0]     CRC16_POLY = 16'h8005;

    // Framing
    localparam int SYNC_BITS    = 8;
    localparam int STUFF_RUN    = 6;
    localparam int EOP_SE0_BITS = 2;

    localparam int COUNT_W = 8;

endpackage

`default_nettype wire

// ==== verilog/usbTxIfs.sv ====
// Command and bit-stream interfaces between the USB transmit stages
`timescale 1ns/1ps
`default_nettype none

interface cmdIf;
    import usbTxPkg::*;

    logic                  start;
    pktKindT               kind;
    logic [DEV_ADDR_W-1:0] devAddr;
    logic [ENDP_W-1:0]     endp;
    logic [PAYLOAD_W-1:0]  payload;
    logic                  busy;
    logic                  done;

    // Register decode issues commands
    modport master (
        output start, kind, devAddr, endp, payload,
        input  busy, done
    );

    // Serializer executes them
    modport slave (
        input  start, kind, devAddr, endp, payload,
        output busy, done
    );
endinterface

interface bitIf;
    import usbTxPkg::*;

    logic    valid;
    busState symbol;
    logic    stuffOn;
    logic    ready;

    modport source (
        output valid, symbol, stuffOn,
        input  ready
    );

    modport sink (
        input  valid, symbol, stuffOn,
        output ready
    );
endinterface

`default_nettype wire

// ==== verilog/apbRegs.sv ====
// APB register block that holds the payload, issues packet commands and reports status
`timescale 1ns/1ps
`default_nettype none

module apbRegs (
    input  logic                        clk,
    input  logic                        rst_L,
    input  logic                        pSel,
    input  logic                        pEnable,
    input  logic                        pWrite,
    input  logic [7:0]                  pAddr,
    input  logic [usbTxPkg::APB_DW-1:0] pWdata,
    output logic [usbTxPkg::APB_DW-1:0] pRdata,
    output logic                        pReady,
    output logic                        pSlverr,
    cmdIf.master                        cmd
);
    import usbTxPkg::*;

    logic [APB_DW-1:0]     dataLo;
    logic [APB_DW-1:0]     dataHi;
    logic [COUNT_W-1:0]    sentCount;
    logic [KIND_W-1:0]     kindField;
    pktKindT               ctrlKind;
    logic [DEV_ADDR_W-1:0] ctrlAddr;
    logic [ENDP_W-1:0]     ctrlEndp;
    logic                  startReg;
    logic                  access;
    logic                  mapped;
    logic                  ctrlWrite;
    logic                  linkBusy;
    logic                  kindOk;
    logic                  accept;

    // No wait states
    assign pReady = 1'b1;
    assign access = pSel && pEnable && pReady;

    always_comb begin
        case (pAddr)
            CTRL_ADDR, DATA_LO_ADDR, DATA_HI_ADDR, STATUS_ADDR: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign kindField = pWdata[KIND_LSB +: KIND_W];
    assign kindOk    = kindField inside {kindOut, kindIn, kindData0, kindAck, kindNak};

    // A pending start counts as busy until the serializer picks it up
    assign linkBusy  = cmd.busy || startReg;
    assign ctrlWrite = access && pWrite && (pAddr == CTRL_ADDR);
    assign accept    = ctrlWrite && !linkBusy && kindOk;
    assign pSlverr   = access && (!mapped || (ctrlWrite && (linkBusy || !kindOk)));

    always_comb begin
        case (pAddr)
            CTRL_ADDR:    pRdata = {{(APB_DW-ENDP_W-DEV_ADDR_W-KIND_W){1'b0}},
                                    ctrlEndp, ctrlAddr, ctrlKind};
            DATA_LO_ADDR: pRdata = dataLo;
            DATA_HI_ADDR: pRdata = dataHi;
            STATUS_ADDR:  pRdata = {{(APB_DW-8-COUNT_W){1'b0}}, sentCount, 7'b0, cmd.busy};
            default:      pRdata = '0;
        endcase
    end

    // Payload words
    always_ff @(posedge clk) begin
        if (access && pWrite && (pAddr == DATA_LO_ADDR)) begin
            dataLo <= pWdata;
        end
        if (access && pWrite && (pAddr == DATA_HI_ADDR)) begin
            dataHi <= pWdata;
        end
    end

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            startReg  <= 1'b0;
            sentCount <= '0;
            ctrlKind  <= kindOut;
            ctrlAddr  <= '0;
            ctrlEndp  <= '0;
        end else begin
            startReg <= accept;
            if (accept) begin
                ctrlKind <= pktKindT'(kindField);
                ctrlAddr <= pWdata[ADDR_LSB +: DEV_ADDR_W];
                ctrlEndp <= pWdata[ENDP_LSB +: ENDP_W];
            end
            if (cmd.done) begin
                sentCount <= sentCount + 1'b1;
            end
        end
    end

    assign cmd.start   = startReg;
    assign cmd.kind    = ctrlKind;
    assign cmd.devAddr = ctrlAddr;
    assign cmd.endp    = ctrlEndp;
    assign cmd.payload = {dataHi, dataLo};

    // The serializer must be idle whenever a new command is launched
    startWhileIdle: assert property (@(posedge clk) disable iff (!rst_L)
        $rose(cmd.start) |-> !cmd.busy)
        else $error("start raised while the serializer is busy");

endmodule

`default_nettype wire

// ==== verilog/crcSerial.sv ====
// Serial Galois LFSR CRC generator taking one data bit per clock
`timescale 1ns/1ps
`default_nettype none

module crcSerial #(
    parameter int               WIDTH = 5,
    parameter logic [WIDTH-1:0] POLY  = 5'h05
) (
    input  logic             clk,
    input  logic             rst_L,
    input  logic             clear,
    input  logic             shift,
    input  logic             dataBit,
    output logic [WIDTH-1:0] crc
);

    logic feedback;

    // Incoming bit meets the MSB before the register shifts up
    assign feedback = dataBit ^ crc[WIDTH-1];

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1;
        end else if (shift) begin
            crc <= {crc[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/packetSerializer.sv ====
// Packet serializer that emits SYNC, PID, fields, CRC and EOP one symbol at a time
`timescale 1ns/1ps
`default_nettype none

module packetSerializer (
    input logic  clk,
    input logic  rst_L,
    cmdIf.slave  cmd,
    bitIf.source bits
);
    import usbTxPkg::*;

    typedef enum logic [2:0] {sIdle, sSync, sPid, sField, sCrc, sEop} serState;

    serState              state;
    logic [5:0]           bitCnt;
    logic [5:0]           fieldLast;
    logic [PAYLOAD_W-1:0] fieldReg;
    logic [7:0]           pidByte;
    logic                 isData;
    logic                 isHandshake;
    pidT                  pidVal;
    logic                 accepted;
    logic                 lastBit;
    logic                 fieldShift;
    logic [CRC5_W-1:0]    crc5;
    logic [CRC16_W-1:0]   crc16;

    function automatic pidT kindToPid(input pktKindT k);
        case (k)
            kindOut:   return pidOut;
            kindIn:    return pidIn;
            kindData0: return pidData0;
            kindAck:   return pidAck;
            default:   return pidNak;
        endcase
    endfunction

    function automatic busState toSym(input logic b);
        return b ? busJ : busK;
    endfunction

    assign pidVal     = kindToPid(cmd.kind);
    assign accepted   = bits.valid && bits.ready;
    assign fieldShift = accepted && (state == sField);
    assign fieldLast  = isData ? 6'(PAYLOAD_W - 1) : 6'(DEV_ADDR_W + ENDP_W - 1);

    always_comb begin
        case (state)
            sSync:   lastBit = (bitCnt == 6'(SYNC_BITS - 1));
            sPid:    lastBit = (bitCnt == 6'd7);
            sField:  lastBit = (bitCnt == fieldLast);
            sCrc:    lastBit = (bitCnt == 6'd0);
            sEop:    lastBit = (bitCnt == 6'(EOP_SE0_BITS));
            default: lastBit = 1'b0;
        endcase
    end

    // Current symbol, which only moves on an accepted transfer
    always_comb begin
        case (state)
            sSync:   bits.symbol = toSym(bitCnt == 6'(SYNC_BITS - 1));
            sPid:    bits.symbol = toSym(pidByte[bitCnt[2:0]]);
            sField:  bits.symbol = toSym(fieldReg[0]);
            sCrc:    bits.symbol = isData ? toSym(~crc16[bitCnt[3:0]])
                                          : toSym(~crc5[bitCnt[2:0]]);
            sEop:    bits.symbol = (bitCnt < 6'(EOP_SE0_BITS)) ? busSe0 : busJ;
            default: bits.symbol = busJ;
        endcase
    end

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            state  <= sIdle;
            bitCnt <= '0;
        end else if (state == sIdle) begin
            if (cmd.start) begin
                state  <= sSync;
                bitCnt <= '0;
            end
        end else if (accepted) begin
            if (lastBit) begin
                bitCnt <= '0;
                case (state)
                    sSync:   state <= sPid;
                    sPid:    state <= isHandshake ? sEop : sField;
                    sField: begin
                        state  <= sCrc;
                        bitCnt <= isData ? 6'(CRC16_W - 1) : 6'(CRC5_W - 1);
                    end
                    sCrc:    state <= sEop;
                    default: state <= sIdle;
                endcase
            end else if (state == sCrc) begin
                // CRC goes out MSB first
                bitCnt <= bitCnt - 1'b1;
            end else begin
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // Command latch and field shifter
    always_ff @(posedge clk) begin
        if ((state == sIdle) && cmd.start) begin
            pidByte     <= {~pidVal, pidVal};
            isData      <= (cmd.kind == kindData0);
            isHandshake <= (cmd.kind inside {kindAck, kindNak});
            if (cmd.kind == kindData0) begin
                fieldReg <= cmd.payload;
            end else begin
                fieldReg <= {{(PAYLOAD_W-DEV_ADDR_W-ENDP_W){1'b0}}, cmd.endp, cmd.devAddr};
            end
        end else if (fieldShift) begin
            fieldReg <= fieldReg >> 1;
        end
    end

    crcSerial #(.WIDTH(CRC5_W), .POLY(CRC5_POLY)) crc5Gen (
        .clk     (clk),
        .rst_L   (rst_L),
        .clear   (cmd.start),
        .shift   (fieldShift && !isData),
        .dataBit (fieldReg[0]),
        .crc     (crc5)
    );

    crcSerial #(.WIDTH(CRC16_W), .POLY(CRC16_POLY)) crc16Gen (
        .clk     (clk),
        .rst_L   (rst_L),
        .clear   (cmd.start),
        .shift   (fieldShift && isData),
        .dataBit (fieldReg[0]),
        .crc     (crc16)
    );

    assign bits.valid   = (state != sIdle);
    assign bits.stuffOn = (state inside {sPid, sField, sCrc});
    assign cmd.busy     = (state != sIdle);
    assign cmd.done     = accepted && (state == sEop) && lastBit;

    // A stalled symbol must wait unchanged for the line coder
    symbolHeld: assert property (@(posedge clk) disable iff (!rst_L)
        (bits.valid && !bits.ready) |=> (bits.valid && $stable(bits.symbol)))
        else $error("symbol changed while the line coder stalled");

endmodule

`default_nettype wire

// ==== verilog/lineCoder.sv ====
// Line coder with bit stuffing, NRZI coding and dp/dm/oe drive
`timescale 1ns/1ps
`default_nettype none

module lineCoder (
    input  logic clk,
    input  logic rst_L,
    bitIf.sink   bits,
    output logic dp,
    output logic dm,
    output logic oe
);
    import usbTxPkg::*;

    localparam int RUN_W = $clog2(STUFF_RUN + 1);

    logic [RUN_W-1:0] onesCnt;
    logic             stuffNow;
    logic             accepted;
    logic             sendGo;
    busState          sendSym;
    busState          lineState;

    // After a full run of ones a zero goes in and the source waits
    assign stuffNow   = (onesCnt == RUN_W'(STUFF_RUN));
    assign bits.ready = !stuffNow;
    assign accepted   = bits.valid && bits.ready;
    assign sendGo     = stuffNow || accepted;
    assign sendSym    = stuffNow ? busK : bits.symbol;

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            onesCnt   <= '0;
            lineState <= busJ;
            oe        <= 1'b0;
        end else begin
            oe <= sendGo;

            if (stuffNow) begin
                onesCnt <= '0;
            end else if (accepted) begin
                if (bits.stuffOn && (bits.symbol == busJ)) begin
                    onesCnt <= onesCnt + 1'b1;
                end else begin
                    onesCnt <= '0;
                end
            end

            // NRZI coding where a zero toggles the line and a one holds it
            if (sendGo) begin
                if (sendSym == busSe0) begin
                    lineState <= busSe0;
                end else if (lineState == busSe0) begin
                    lineState <= sendSym;
                end else if (sendSym == busK) begin
                    lineState <= (lineState == busJ) ? busK : busJ;
                end
            end
        end
    end

    assign dp = (lineState == busJ);
    assign dm = (lineState == busK);

    // Each packet has to leave the line at J once the driver turns off
    idleAtJ: assert property (@(posedge clk) disable iff (!rst_L)
        !oe |-> (lineState == busJ))
        else $error("line not back at J while oe is low");

endmodule

`default_nettype wire

// ==== verilog/usbTxHost.sv ====
// USB transmit host top level joining register decode, serializer and line coder
`timescale 1ns/1ps
`default_nettype none

module usbTxHost (
    input  logic                        clk,
    input  logic                        rst_L,
    input  logic                        pSel,
    input  logic                        pEnable,
    input  logic                        pWrite,
    input  logic [7:0]                  pAddr,
    input  logic [usbTxPkg::APB_DW-1:0] pWdata,
    output logic [usbTxPkg::APB_DW-1:0] pRdata,
    output logic                        pReady,
    output logic                        pSlverr,
    output logic                        dp,
    output logic                        dm,
    output logic                        oe
);

    cmdIf cmdBus ();
    bitIf bitBus ();

    apbRegs apbRegs_i (
        .clk     (clk),
        .rst_L   (rst_L),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pReady  (pReady),
        .pSlverr (pSlverr),
        .cmd     (cmdBus.master)
    );

    packetSerializer packetSerializer_i (
        .clk   (clk),
        .rst_L (rst_L),
        .cmd   (cmdBus.slave),
        .bits  (bitBus.source)
    );

    lineCoder lineCoder_i (
        .clk   (clk),
        .rst_L (rst_L),
        .bits  (bitBus.sink),
        .dp    (dp),
        .dm    (dm),
        .oe    (oe)
    );

endmodule

`default_nettype wire

// ==== sim/lineMonitor.sv ====
// Line monitor that undoes NRZI and bit stuffing and rebuilds each packet with its CRC check
`timescale 1ns/1ps
`default_nettype none

module lineMonitor (
    input  logic        clk,
    input  logic        rst_L,
    input  logic        dp,
    input  logic        dm,
    input  logic        oe,
    output logic        pktValid,
    output logic [7:0]  pidByte,
    output logic [63:0] fieldBits,
    output int          bitCount,
    output int          stuffCount,
    output logic        syncOk,
    output logic        stuffOk,
    output logic        crcOk,
    output logic        eopOk
);
    import usbTxPkg::*;

    localparam int TOKEN_BITS = 8 + DEV_ADDR_W + ENDP_W + CRC5_W;
    localparam int DATA_BITS  = 8 + PAYLOAD_W + CRC16_W;

    busState     sym;
    busState     prevSym;
    logic [95:0] rxBits;
    logic [7:0]  syncBits;
    logic        inPkt;
    logic        bitVal;
    int          rawCnt;
    int          onesRun;
    int          se0Cnt;

    // Recompute the CRC over the field bits and compare with the one received
    function automatic logic crcMatches(input int fieldLen, input int width,
                                        input logic [15:0] poly);
        logic [15:0] lfsr;
        logic [15:0] mask;
        logic [15:0] rxCrc;
        logic        fb;
        mask  = 16'((32'd1 << width) - 1);
        lfsr  = mask;
        rxCrc = '0;
        for (int i = 0; i < fieldLen; i++) begin
            fb   = rxBits[8 + i] ^ lfsr[width - 1];
            lfsr = ((lfsr << 1) ^ (fb ? poly : 16'h0)) & mask;
        end
        // Complemented on the line, MSB first
        for (int i = 0; i < width; i++) begin
            rxCrc = (rxCrc << 1) | 16'(rxBits[8 + fieldLen + i]);
        end
        return rxCrc == (~lfsr & mask);
    endfunction

    always @(negedge clk) begin
        pktValid = 1'b0;
        sym = dp ? busJ : (dm ? busK : busSe0);
        if (!rst_L) begin
            inPkt      = 1'b0;
            prevSym    = busJ;
            pidByte    = '0;
            fieldBits  = '0;
            bitCount   = 0;
            stuffCount = 0;
            syncOk     = 1'b0;
            stuffOk    = 1'b0;
            crcOk      = 1'b0;
            eopOk      = 1'b0;
        end else if (oe) begin
            if (!inPkt) begin
                inPkt      = 1'b1;
                rawCnt     = 0;
                onesRun    = 0;
                se0Cnt     = 0;
                bitCount   = 0;
                stuffCount = 0;
                stuffOk    = 1'b1;
                rxBits     = '0;
            end
            if (sym == busSe0) begin
                se0Cnt++;
            end else if (se0Cnt > 0) begin
                // The J after the SE0 bits closes the packet
                inPkt     = 1'b0;
                eopOk     = (se0Cnt == EOP_SE0_BITS);
                syncOk    = (syncBits == 8'h80);
                pidByte   = rxBits[7:0];
                fieldBits = '0;
                if (bitCount == TOKEN_BITS) begin
                    fieldBits[10:0] = rxBits[18:8];
                    crcOk = crcMatches(DEV_ADDR_W + ENDP_W, CRC5_W, 16'(CRC5_POLY));
                end else if (bitCount == DATA_BITS) begin
                    fieldBits = rxBits[71:8];
                    crcOk = crcMatches(PAYLOAD_W, CRC16_W, CRC16_POLY);
                end else begin
                    crcOk = (bitCount == 8);
                end
                pktValid = 1'b1;
            end else begin
                // Same level as before is a one, a change is a zero
                bitVal = (sym == prevSym);
                if (rawCnt < SYNC_BITS) begin
                    syncBits[rawCnt] = bitVal;
                    rawCnt++;
                end else if (onesRun == STUFF_RUN) begin
                    if (bitVal) begin
                        stuffOk = 1'b0;
                    end
                    onesRun = 0;
                    stuffCount++;
                end else begin
                    if (bitCount < 96) begin
                        rxBits[bitCount] = bitVal;
                    end
                    bitCount++;
                    onesRun = bitVal ? onesRun + 1 : 0;
                end
            end
            prevSym = sym;
        end
    end

endmodule

`default_nettype wire

// ==== sim/usbTxHostTb.sv ====
// Testbench for the USB transmit host, APB commands in and packets checked on the line
`timescale 1ns/1ps
`default_nettype none

module usbTxHostTb;
    import usbTxPkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int TEST_COUNT  = 20;
    localparam int LONGEST_PKT = 130;
    localparam int LIMIT_NS    = TEST_COUNT * 20 * LONGEST_PKT * CLK_PERIOD;

    logic              clk;
    logic              rst_L;
    logic              pSel;
    logic              pEnable;
    logic              pWrite;
    logic [7:0]        pAddr;
    logic [APB_DW-1:0] pWdata;
    logic [APB_DW-1:0] pRdata;
    logic              pReady;
    logic              pSlverr;
    logic              dp;
    logic              dm;
    logic              oe;
    logic              pktValid;
    logic [7:0]        pidByte;
    logic [63:0]       fieldBits;
    int                bitCount;
    int                stuffCount;
    logic              syncOk;
    logic              stuffOk;
    logic              crcOk;
    logic              eopOk;
    int                seed;
    int                expCount;
    pktKindT           kind;
    logic [31:0]       rnd;
    logic [31:0]       rnd2;
    logic [31:0]       rdData;
    logic              err;

    usbTxHost usbTxHost_i (
        .clk(clk), .rst_L(rst_L), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
        .pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady),
        .pSlverr(pSlverr), .dp(dp), .dm(dm), .oe(oe)
    );

    lineMonitor lineMonitor_i (
        .clk(clk), .rst_L(rst_L), .dp(dp), .dm(dm), .oe(oe), .pktValid(pktValid),
        .pidByte(pidByte), .fieldBits(fieldBits), .bitCount(bitCount),
        .stuffCount(stuffCount), .syncOk(syncOk), .stuffOk(stuffOk), .crcOk(crcOk),
        .eopOk(eopOk)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stopOnError(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    oeFallsAfterEop: assert property (@(posedge clk) disable iff (!rst_L) pktValid |=> !oe)
        else stopOnError("oe still high after the EOP");
    idleLineIsJ: assert property (@(posedge clk) disable iff (!rst_L) !oe |-> (dp && !dm))
        else stopOnError("line is not J while oe is low");
    noWaitStates: assert property (@(posedge clk) disable iff (!rst_L)
        (pSel && pEnable) |-> pReady)
        else stopOnError("pReady low in an access phase");

    function automatic logic [3:0] expectedPid(input pktKindT k);
        case (k)
            kindOut:   return 4'b0001;
            kindIn:    return 4'b1001;
            kindData0: return 4'b0011;
            kindAck:   return 4'b0010;
            default:   return 4'b1010;
        endcase
    endfunction

    function automatic logic [31:0] ctrlWord(input pktKindT k, input logic [6:0] addr,
                                             input logic [3:0] endp);
        return (32'(endp) << ENDP_LSB) | (32'(addr) << ADDR_LSB) | 32'(k);
    endfunction

    // One APB transfer with read data sampled mid-cycle in the access phase
    task automatic apbAccess(input logic write, input logic [7:0] addr, input logic [31:0] data,
                             output logic [31:0] rdata, output logic slvErr);
        @(posedge clk);
        #1;
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = write;
        pAddr   = addr;
        pWdata  = data;
        @(posedge clk);
        #1;
        pEnable = 1'b1;
        @(negedge clk);
        rdata  = pRdata;
        slvErr = pSlverr;
        @(posedge clk);
        #1;
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic issueCommand(input pktKindT k, input logic [6:0] addr, input logic [3:0] endp,
                                input logic [63:0] payload);
        if (k == kindData0) begin
            apbAccess(1'b1, DATA_LO_ADDR, payload[31:0], rdData, err);
            apbAccess(1'b1, DATA_HI_ADDR, payload[63:32], rdData, err);
        end
        apbAccess(1'b1, CTRL_ADDR, ctrlWord(k, addr, endp), rdData, err);
        assert (!err) else stopOnError("valid CTRL write answered with pSlverr");
        expCount++;
    endtask

    task automatic checkPacket(input pktKindT k, input logic [6:0] addr, input logic [3:0] endp,
                               input logic [63:0] payload);
        logic [3:0] pid;
        int         expBits;
        pid     = expectedPid(k);
        expBits = (k == kindData0) ? 88 : ((k inside {kindAck, kindNak}) ? 8 : 24);
        while (!pktValid) begin
            @(posedge clk);
        end
        assert (syncOk) else stopOnError("SYNC is not KJKJKJKK");
        assert (eopOk) else stopOnError("EOP is not two SE0 bits and a J");
        assert (stuffOk) else stopOnError("six ones not followed by a stuffed zero");
        assert (bitCount == expBits)
            else stopOnError($sformatf("%0d packet bits, expected %0d", bitCount, expBits));
        assert (pidByte == {~pid, pid})
            else stopOnError($sformatf("PID byte %h, expected %h", pidByte, {~pid, pid}));
        assert (crcOk) else stopOnError("CRC on the line does not match the fields");
        if (expBits == 24) begin
            assert (fieldBits[10:0] == {endp, addr})
                else stopOnError($sformatf("token fields %h, expected %h",
                                           fieldBits[10:0], {endp, addr}));
        end
        if (k == kindData0) begin
            assert (fieldBits == payload)
                else stopOnError($sformatf("payload %h, expected %h", fieldBits, payload));
        end
        // Poll STATUS until busy drops and compare the count
        rdData = 32'h1;
        while (rdData[0]) begin
            apbAccess(1'b0, STATUS_ADDR, 32'h0, rdData, err);
        end
        assert (!err && rdData[15:8] == expCount[7:0])
            else stopOnError($sformatf("STATUS count %0d, expected %0d", rdData[15:8], expCount));
    endtask

    initial begin
        #(LIMIT_NS);
        $display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed     = 32'h1e93b8eb;
        expCount = 0;
        rst_L    = 1'b0;
        pSel     = 1'b0;
        pEnable  = 1'b0;
        pWrite   = 1'b0;
        pAddr    = 8'h0;
        pWdata   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_L = 1'b1;

        @(posedge clk);
        #1;
        assert (!oe && dp && !dm) else stopOnError("line not idle after reset");
        apbAccess(1'b0, STATUS_ADDR, 32'h0, rdData, err);
        assert (!err && rdData == 32'h0)
            else stopOnError($sformatf("STATUS %h after reset, expected 0", rdData));

        // Tokens
        for (int i = 0; i < 6; i++) begin
            rnd  = $random(seed);
            kind = (i % 2 == 1) ? kindIn : kindOut;
            issueCommand(kind, rnd[6:0], rnd[10:7], 64'h0);
            checkPacket(kind, rnd[6:0], rnd[10:7], 64'h0);
        end

        // DATA0 payloads with a final all-ones payload that forces stuffing
        for (int i = 0; i < 3; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            issueCommand(kindData0, 7'h0, 4'h0, {rnd2, rnd});
            checkPacket(kindData0, 7'h0, 4'h0, {rnd2, rnd});
        end
        issueCommand(kindData0, 7'h0, 4'h0, '1);
        checkPacket(kindData0, 7'h0, 4'h0, '1);
        assert (stuffCount >= 10)
            else stopOnError($sformatf("%0d stuffed bits in all-ones packet", stuffCount));

        issueCommand(kindAck, 7'h0, 4'h0, 64'h0);
        checkPacket(kindAck, 7'h0, 4'h0, 64'h0);
        issueCommand(kindNak, 7'h0, 4'h0, 64'h0);
        checkPacket(kindNak, 7'h0, 4'h0, 64'h0);

        // Second CTRL write lands while the first packet is going out
        rnd = $random(seed);
        issueCommand(kindOut, rnd[6:0], rnd[10:7], 64'h0);
        apbAccess(1'b1, CTRL_ADDR, ctrlWord(kindNak, 7'h0, 4'h0), rdData, err);
        assert (err) else stopOnError("CTRL write while busy not answered with pSlverr");
        checkPacket(kindOut, rnd[6:0], rnd[10:7], 64'h0);

        apbAccess(1'b1, 8'h10, 32'h1234, rdData, err);
        assert (err) else stopOnError("unmapped write not answered with pSlverr");
        apbAccess(1'b0, 8'h14, 32'h0, rdData, err);
        assert (err) else stopOnError("unmapped read not answered with pSlverr");
        apbAccess(1'b1, CTRL_ADDR, 32'h5, rdData, err);
        assert (err) else stopOnError("invalid kind not answered with pSlverr");
        repeat (4) @(posedge clk);
        #1;
        assert (!oe) else stopOnError("invalid kind started a packet");

        rnd = $random(seed);
        apbAccess(1'b1, DATA_LO_ADDR, 32'ha5c3_0f96, rdData, err);
        apbAccess(1'b1, DATA_HI_ADDR, rnd, rdData, err);
        apbAccess(1'b0, DATA_LO_ADDR, 32'h0, rdData, err);
        assert (!err && rdData == 32'ha5c3_0f96)
            else stopOnError($sformatf("DATA_LO read %h, expected a5c30f96", rdData));
        apbAccess(1'b0, DATA_HI_ADDR, 32'h0, rdData, err);
        assert (!err && rdData == rnd)
            else stopOnError($sformatf("DATA_HI read %h, expected %h", rdData, rnd));

        // STATUS ignores writes and still holds the count
        apbAccess(1'b1, STATUS_ADDR, 32'hffff_ffff, rdData, err);
        assert (!err) else stopOnError("STATUS write answered with pSlverr");
        apbAccess(1'b0, STATUS_ADDR, 32'h0, rdData, err);
        assert (!err && rdData[0] == 1'b0 && rdData[15:8] == expCount[7:0])
            else stopOnError($sformatf("STATUS %h, expected count %0d idle", rdData, expCount));

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== usbTxHost.f ====
verilog/usbTxPkg.sv
verilog/usbTxIfs.sv
verilog/apbRegs.sv
verilog/crcSerial.sv
verilog/packetSerializer.sv
verilog/lineCoder.sv
verilog/usbTxHost.sv
sim/lineMonitor.sv
sim/usbTxHostTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module usbTxHostTb -f usbTxHost.f

simOut=$(./obj_dir/VusbTxHostTb || true)
echo "$simOut"

if echo "$simOut" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
